// ==== hdl/igr_dpc_pkg.sv ====
//----------------------------------------------------------------------
// shared sizes and types for the ingress data path control block
// receive word with ecc, segment metadata, timestamp
// captured segment and per-port packet buffer write struct
//----------------------------------------------------------------------

package igr_dpc_pkg;

  //----------------------------------------------------------------------
  // sizes
  //----------------------------------------------------------------------

  // logical ports sharing one receive bus
  localparam int NUM_PORTS = 4;
  // port number width follows the port count
  localparam int PORT_W    = $clog2(NUM_PORTS);

  // data words carried per bus cycle
  localparam int NUM_WORDS = 8;
  // count must reach NUM_WORDS itself, so 0..8 needs 4 bits
  localparam int CNT_W     = $clog2(NUM_WORDS + 1);
  // word / byte position fields
  localparam int POS_W     = 3;

  // priority flow control classes
  localparam int NUM_TC    = 8;
  localparam int TC_W      = $clog2(NUM_TC);

  localparam int DATA_W    = 64;
  localparam int ECC_W     = 8;
  localparam int TS_W      = 32;

  //----------------------------------------------------------------------
  // bus types
  //----------------------------------------------------------------------

  // one data word plus its ecc byte, ecc passes through untouched
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [ECC_W-1:0]  ecc;
  } data64_w_ecc_t;

  // segment metadata as it arrives from the port logic
  typedef struct packed {
    logic             multi;
    logic             fast;
    logic             fcs_hint;
    logic             dei;
    logic             error;
    logic             eop;
    logic [POS_W-1:0] eop_pos;
    logic [POS_W-1:0] byte_pos;
    logic             sop;
    logic [POS_W-1:0] sop_pos;
    logic [TC_W-1:0]  tc;
  } epl_md_t;

  // receive timestamp
  typedef logic [TS_W-1:0] epl_ts_t;

  // buffer metadata, valid word count ahead of the port fields
  typedef struct packed {
    logic [CNT_W-1:0] word_cnt;
    epl_md_t          epl;
  } dpc_md_t;

  // timestamp and metadata group as the buffer sees it
  typedef struct packed {
    epl_ts_t ts;
    dpc_md_t md;
  } dpc_tsmd_t;

  // segment broadcast from the input stage to every lane
  typedef struct packed {
    epl_ts_t                       ts;
    dpc_md_t                       md;
    data64_w_ecc_t [0:NUM_WORDS-1] d;
  } dpc_seg_t;

  // per-port packet buffer write
  typedef struct packed {
    logic                          v;
    dpc_tsmd_t                     tsmd;
    data64_w_ecc_t [0:NUM_WORDS-1] d;
  } dpc_pb_t;

endpackage

// ==== hdl/igr_rx_stage.sv ====
//----------------------------------------------------------------------
// receive bus input stage
// bus register, valid word count, one-hot port decode
// buffer metadata build and priority pause state
//----------------------------------------------------------------------

module igr_rx_stage (
  input  logic                                                    i_cclk,
  input  logic                                                    i_rst,
  // receive bus
  input  logic [igr_dpc_pkg::NUM_WORDS-1:0]                       i_rx_data_v,
  input  logic [igr_dpc_pkg::PORT_W-1:0]                          i_rx_port_num,
  input  igr_dpc_pkg::data64_w_ecc_t [0:igr_dpc_pkg::NUM_WORDS-1] i_rx_data,
  input  igr_dpc_pkg::epl_md_t                                    i_rx_md,
  input  igr_dpc_pkg::epl_ts_t                                    i_rx_ts,
  // priority flow control update
  input  logic                                                    i_pfc_strobe,
  input  logic                                                    i_pfc_xoff,
  input  logic [igr_dpc_pkg::TC_W-1:0]                            i_pfc_tc,
  // toward the lanes
  output igr_dpc_pkg::dpc_seg_t                                   o_seg,
  output logic [igr_dpc_pkg::NUM_PORTS-1:0]                       o_port_sel,
  output logic [igr_dpc_pkg::NUM_TC-1:0]                          o_pause_tc
);
  import igr_dpc_pkg::*;

  // stage 1 copies of the bus
  logic [NUM_WORDS-1:0]          s1_data_v;
  logic [PORT_W-1:0]             s1_port_num;
  data64_w_ecc_t [0:NUM_WORDS-1] s1_data;
  epl_md_t                       s1_md;
  epl_ts_t                       s1_ts;

  // decoded from stage 1
  logic [CNT_W-1:0]              s1_cnt_ones;
  logic                          s1_any_v;
  logic [NUM_PORTS-1:0]          s1_port_dec;

  //----------------------------------------------------------------------
  // input register
  //----------------------------------------------------------------------

  // stage 1 word valid mask
  always_ff @(posedge i_cclk) begin
    if (i_rst) begin
      s1_data_v <= '0;
    end else begin
      s1_data_v <= i_rx_data_v;
    end
  end

  // stage 1 port number, data, metadata and timestamp
  always_ff @(posedge i_cclk) begin
    s1_port_num <= i_rx_port_num;
    s1_data     <= i_rx_data;
    s1_md       <= i_rx_md;
    s1_ts       <= i_rx_ts;
  end

  //----------------------------------------------------------------------
  // count, decode, metadata
  //----------------------------------------------------------------------

  // ones in the mask, 0..8
  always_comb begin
    s1_cnt_ones = '0;
    for (int w = 0; w < NUM_WORDS; w++) begin
      s1_cnt_ones = s1_cnt_ones + CNT_W'(s1_data_v[w]);
    end
  end

  assign s1_any_v = |s1_data_v;

  // port number to one-hot
  always_comb begin
    s1_port_dec              = '0;
    s1_port_dec[s1_port_num] = 1'b1;
  end

  // no lane owns an idle cycle
  assign o_port_sel = s1_port_dec & {NUM_PORTS{s1_any_v}};

  // same segment goes to every lane, the select picks the owner
  assign o_seg.ts          = s1_ts;
  assign o_seg.md.word_cnt = s1_cnt_ones;
  assign o_seg.md.epl      = s1_md;
  assign o_seg.d           = s1_data;

  //----------------------------------------------------------------------
  // pause state, one level per traffic class
  //----------------------------------------------------------------------

  // strobe writes xoff into the named class, others hold
  always_ff @(posedge i_cclk) begin
    if (i_rst) begin
      o_pause_tc <= '0;
    end else if (i_pfc_strobe) begin
      o_pause_tc[i_pfc_tc] <= i_pfc_xoff;
    end
  end

  // a live mask must pick exactly one lane on the next cycle
  a_sel_busy: assert property (@(posedge i_cclk) disable iff (i_rst)
    |i_rx_data_v |=> $onehot(o_port_sel));

endmodule

// ==== hdl/igr_port_lane.sv ====
//----------------------------------------------------------------------
// per-port segment capture
// in-packet tracking and drop of segments with no start of packet
//----------------------------------------------------------------------

module igr_port_lane (
  input  logic                  i_cclk,
  input  logic                  i_rst,
  // from the input stage
  input  logic                  i_sel,
  input  igr_dpc_pkg::dpc_seg_t i_seg,
  // toward the drain
  output igr_dpc_pkg::dpc_pb_t  o_pb,
  output logic                  o_drop
);

  // set between an accepted sop and its eop
  logic in_pkt_q;

  logic seg_sop;
  logic seg_eop;
  logic accept;
  logic orphan;

  //----------------------------------------------------------------------
  // accept / drop decision
  //----------------------------------------------------------------------

  assign seg_sop = i_seg.md.epl.sop;
  assign seg_eop = i_seg.md.epl.eop;

  // sop always opens a packet, even one already open
  // a continuation is only good inside a packet
  assign accept = i_sel & (seg_sop | in_pkt_q);

  // selected but no packet to belong to
  assign orphan = i_sel & ~accept;

  //----------------------------------------------------------------------
  // capture register
  //----------------------------------------------------------------------

  always_ff @(posedge i_cclk) begin
    if (i_rst) begin
      in_pkt_q <= 1'b0;
      o_pb     <= '0;
      o_drop   <= 1'b0;
    end else begin
      // valid and drop are single cycle pulses
      o_pb.v <= accept;
      o_drop <= orphan;
      if (accept) begin
        // single segment packet (sop and eop) leaves the flag clear
        in_pkt_q     <= ~seg_eop;
        o_pb.tsmd.ts <= i_seg.ts;
        o_pb.tsmd.md <= i_seg.md;
        o_pb.d       <= i_seg.d;
      end
      // dropped or idle cycles hold the last captured fields
    end
  end

  // a drop never shows up alongside a buffer write
  a_drop_excl: assert property (@(posedge i_cclk) disable iff (i_rst)
    !(o_drop && o_pb.v));

endmodule

// ==== hdl/igr_pb_drain.sv ====
//----------------------------------------------------------------------
// packet buffer drain
// lane outputs onto the buffer write bus
// saturating drop counters, one per port
//----------------------------------------------------------------------

module igr_pb_drain #(
  parameter int DROP_CNT_W = 16
) (
  input  logic                                                i_cclk,
  input  logic                                                i_rst,
  // from the lanes
  input  igr_dpc_pkg::dpc_pb_t [igr_dpc_pkg::NUM_PORTS-1:0]   i_lane_pb,
  input  logic [igr_dpc_pkg::NUM_PORTS-1:0]                   i_lane_drop,
  // packet buffer write bus
  output igr_dpc_pkg::dpc_pb_t [igr_dpc_pkg::NUM_PORTS-1:0]   o_dpc_pb,
  // per-port drop counts
  output logic [igr_dpc_pkg::NUM_PORTS-1:0][DROP_CNT_W-1:0]   o_drop_cnt
);
  import igr_dpc_pkg::*;

  // stored counts, the output runs one update ahead of these
  logic [NUM_PORTS-1:0][DROP_CNT_W-1:0] cnt_q;

  //----------------------------------------------------------------------
  // buffer write bus
  //----------------------------------------------------------------------

  // lanes already hold one registered segment each
  assign o_dpc_pb = i_lane_pb;

  //----------------------------------------------------------------------
  // drop counters
  //----------------------------------------------------------------------

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_cnt

    // next count, shown right away so a drop is seen with its pulse
    always_comb begin
      if (i_lane_drop[p] && !(&cnt_q[p])) begin
        o_drop_cnt[p] = cnt_q[p] + DROP_CNT_W'(1);
      end else begin
        // idle, or stuck at all ones
        o_drop_cnt[p] = cnt_q[p];
      end
    end

    always_ff @(posedge i_cclk) begin
      if (i_rst) begin
        cnt_q[p] <= '0;
      end else begin
        cnt_q[p] <= o_drop_cnt[p];
      end
    end

  end

endmodule

// ==== hdl/igr_dpc_top.sv ====
//----------------------------------------------------------------------
// ingress data path control, top level
// input stage, one capture lane per logical port, buffer drain
//----------------------------------------------------------------------

module igr_dpc_top #(
  parameter int DROP_CNT_W = 16
) (
  input  logic                                                    i_cclk,
  input  logic                                                    i_rst,
  // receive bus shared by the logical ports
  input  logic [igr_dpc_pkg::NUM_WORDS-1:0]                       i_rx_data_v,
  input  logic [igr_dpc_pkg::PORT_W-1:0]                          i_rx_port_num,
  input  igr_dpc_pkg::data64_w_ecc_t [0:igr_dpc_pkg::NUM_WORDS-1] i_rx_data,
  input  igr_dpc_pkg::epl_md_t                                    i_rx_md,
  input  igr_dpc_pkg::epl_ts_t                                    i_rx_ts,
  input  logic                                                    i_pfc_strobe,
  input  logic                                                    i_pfc_xoff,
  input  logic [igr_dpc_pkg::TC_W-1:0]                            i_pfc_tc,
  // packet buffer side
  output igr_dpc_pkg::dpc_pb_t [igr_dpc_pkg::NUM_PORTS-1:0]       o_dpc_pb,
  output logic [igr_dpc_pkg::NUM_PORTS-1:0][DROP_CNT_W-1:0]       o_drop_cnt,
  output logic [igr_dpc_pkg::NUM_TC-1:0]                          o_pause_tc
);
  import igr_dpc_pkg::*;

  // input stage to lanes
  dpc_seg_t                  seg;
  logic [NUM_PORTS-1:0]      port_sel;

  // lanes to drain
  dpc_pb_t [NUM_PORTS-1:0]   lane_pb;
  logic [NUM_PORTS-1:0]      lane_drop;

  igr_rx_stage u_rx_stage (
    .i_cclk        (i_cclk),
    .i_rst         (i_rst),
    .i_rx_data_v   (i_rx_data_v),
    .i_rx_port_num (i_rx_port_num),
    .i_rx_data     (i_rx_data),
    .i_rx_md       (i_rx_md),
    .i_rx_ts       (i_rx_ts),
    .i_pfc_strobe  (i_pfc_strobe),
    .i_pfc_xoff    (i_pfc_xoff),
    .i_pfc_tc      (i_pfc_tc),
    .o_seg         (seg),
    .o_port_sel    (port_sel),
    .o_pause_tc    (o_pause_tc)
  );

  // one lane per logical port, all see the same segment
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_lane
    igr_port_lane u_lane (
      .i_cclk (i_cclk),
      .i_rst  (i_rst),
      .i_sel  (port_sel[p]),
      .i_seg  (seg),
      .o_pb   (lane_pb[p]),
      .o_drop (lane_drop[p])
    );
  end

  igr_pb_drain #(
    .DROP_CNT_W (DROP_CNT_W)
  ) u_drain (
    .i_cclk      (i_cclk),
    .i_rst       (i_rst),
    .i_lane_pb   (lane_pb),
    .i_lane_drop (lane_drop),
    .o_dpc_pb    (o_dpc_pb),
    .o_drop_cnt  (o_drop_cnt)
  );

endmodule

// ==== bench/igr_dpc_vectors.svh ====
//----------------------------------------------------------------------
// stimulus table for the ingress data path control testbench
// entry type and one row per applied bus cycle
//----------------------------------------------------------------------

`ifndef IGR_DPC_VECTORS_SVH
`define IGR_DPC_VECTORS_SVH

// flags are multi, fast, fcs_hint, dei, error from msb down
typedef struct packed {
  logic [PORT_W-1:0]    port;
  logic [NUM_WORDS-1:0] mask;
  logic                 sop;
  logic                 eop;
  logic [4:0]           flags;
  logic [TC_W-1:0]      tc;
  epl_ts_t              ts;
  logic                 pfc_strobe;
  logic                 pfc_xoff;
  logic [TC_W-1:0]      pfc_tc;
} vec_t;

localparam int NUM_VEC = 30;

// port  mask   sop   eop   flags  tc    timestamp      pfc stb/xoff/tc
localparam vec_t VECS [NUM_VEC] = '{
  '{2'd0, 8'h00, 1'b0, 1'b0, 5'h00, 3'd0, 32'h0000_0000, 1'b0, 1'b0, 3'd0},
  // single segment packets, word counts 1 to 8
  '{2'd0, 8'h01, 1'b1, 1'b1, 5'h00, 3'd1, 32'h1000_0001, 1'b1, 1'b1, 3'd3},
  '{2'd1, 8'h03, 1'b1, 1'b1, 5'h01, 3'd2, 32'h1000_0002, 1'b0, 1'b0, 3'd0},
  '{2'd2, 8'h07, 1'b1, 1'b1, 5'h02, 3'd3, 32'h1000_0003, 1'b0, 1'b0, 3'd0},
  '{2'd3, 8'h0f, 1'b1, 1'b1, 5'h04, 3'd4, 32'h1000_0004, 1'b1, 1'b1, 3'd5},
  '{2'd0, 8'h1f, 1'b1, 1'b1, 5'h08, 3'd5, 32'h1000_0005, 1'b0, 1'b0, 3'd0},
  '{2'd1, 8'h3f, 1'b1, 1'b1, 5'h10, 3'd6, 32'h1000_0006, 1'b0, 1'b0, 3'd0},
  '{2'd2, 8'h7f, 1'b1, 1'b1, 5'h1f, 3'd7, 32'h1000_0007, 1'b0, 1'b0, 3'd0},
  '{2'd3, 8'hff, 1'b1, 1'b1, 5'h00, 3'd0, 32'h1000_0008, 1'b0, 1'b0, 3'd0},
  '{2'd0, 8'ha5, 1'b1, 1'b1, 5'h15, 3'd2, 32'h1000_0009, 1'b0, 1'b0, 3'd0},
  // empty mask with sop set, nobody owns it
  '{2'd2, 8'h00, 1'b1, 1'b0, 5'h00, 3'd0, 32'h2000_0000, 1'b0, 1'b0, 3'd0},
  // orphans on port 1
  '{2'd1, 8'hff, 1'b0, 1'b0, 5'h00, 3'd1, 32'h3000_0001, 1'b0, 1'b0, 3'd0},
  '{2'd1, 8'h0f, 1'b0, 1'b1, 5'h00, 3'd1, 32'h3000_0002, 1'b0, 1'b0, 3'd0},
  // three segment packet on port 2 then a stray continuation
  '{2'd2, 8'hff, 1'b1, 1'b0, 5'h00, 3'd4, 32'h4000_0001, 1'b0, 1'b0, 3'd0},
  '{2'd2, 8'hff, 1'b0, 1'b0, 5'h02, 3'd4, 32'h4000_0002, 1'b0, 1'b0, 3'd0},
  '{2'd2, 8'h3c, 1'b0, 1'b1, 5'h00, 3'd4, 32'h4000_0003, 1'b0, 1'b0, 3'd0},
  '{2'd2, 8'hff, 1'b0, 1'b0, 5'h00, 3'd4, 32'h4000_0004, 1'b0, 1'b0, 3'd0},
  // ports 0 and 3 interleaved
  '{2'd0, 8'hff, 1'b1, 1'b0, 5'h00, 3'd6, 32'h5000_0001, 1'b0, 1'b0, 3'd0},
  '{2'd3, 8'hff, 1'b1, 1'b0, 5'h04, 3'd3, 32'h5000_0002, 1'b0, 1'b0, 3'd0},
  '{2'd0, 8'hff, 1'b0, 1'b0, 5'h00, 3'd6, 32'h5000_0003, 1'b0, 1'b0, 3'd0},
  '{2'd3, 8'h0f, 1'b0, 1'b1, 5'h04, 3'd3, 32'h5000_0004, 1'b0, 1'b0, 3'd0},
  '{2'd0, 8'h01, 1'b0, 1'b1, 5'h00, 3'd6, 32'h5000_0005, 1'b0, 1'b0, 3'd0},
  '{2'd3, 8'hff, 1'b0, 1'b0, 5'h00, 3'd3, 32'h5000_0006, 1'b0, 1'b0, 3'd0},
  '{2'd0, 8'hff, 1'b0, 1'b0, 5'h00, 3'd6, 32'h5000_0007, 1'b0, 1'b0, 3'd0},
  // pause updates, some riding along with sop inside a packet
  '{2'd0, 8'h00, 1'b0, 1'b0, 5'h00, 3'd0, 32'h6000_0000, 1'b1, 1'b0, 3'd3},
  '{2'd1, 8'hff, 1'b1, 1'b0, 5'h08, 3'd0, 32'h6000_0001, 1'b1, 1'b1, 3'd0},
  '{2'd1, 8'hff, 1'b1, 1'b1, 5'h08, 3'd0, 32'h6000_0002, 1'b1, 1'b0, 3'd5},
  '{2'd0, 8'h00, 1'b0, 1'b0, 5'h00, 3'd0, 32'h6000_0003, 1'b1, 1'b1, 3'd7},
  '{2'd0, 8'h00, 1'b0, 1'b0, 5'h00, 3'd0, 32'h6000_0004, 1'b1, 1'b0, 3'd7},
  '{2'd0, 8'h00, 1'b0, 1'b0, 5'h00, 3'd0, 32'h6000_0005, 1'b0, 1'b0, 3'd0}
};

`endif

// ==== bench/igr_dpc_tb.sv ====
//----------------------------------------------------------------------
// testbench for the ingress data path control top level
// clock, reset, table driven stimulus with a reference model
// compare tasks, cycle limit and closing summary
//----------------------------------------------------------------------

module igr_dpc_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import igr_dpc_pkg::*;

  `include "igr_dpc_vectors.svh"

  localparam int DROP_W     = 16;
  localparam int RST_CYCLES = 8;
  // input to buffer bus latency
  localparam int LAT        = 2;
  localparam int NUM_STEPS  = NUM_VEC + LAT;
  localparam int MAX_CYCLES = RST_CYCLES + NUM_STEPS + 32;
  localparam int SEED       = 90368;

  logic                          cclk;
  logic                          rst;
  logic [NUM_WORDS-1:0]          rx_data_v;
  logic [PORT_W-1:0]             rx_port_num;
  data64_w_ecc_t [0:NUM_WORDS-1] rx_data;
  epl_md_t                       rx_md;
  epl_ts_t                       rx_ts;
  logic                          pfc_strobe;
  logic                          pfc_xoff;
  logic [TC_W-1:0]               pfc_tc;
  dpc_pb_t [NUM_PORTS-1:0]       dpc_pb;
  logic [NUM_PORTS-1:0][DROP_W-1:0] drop_cnt;
  logic [NUM_TC-1:0]             pause_tc;

  // reference model state
  dpc_pb_t           model_pb    [NUM_PORTS];
  logic              in_pkt      [NUM_PORTS];
  logic [DROP_W-1:0] model_cnt   [NUM_PORTS];
  logic [NUM_TC-1:0] model_pause;

  // expected outputs after each step
  dpc_pb_t           exp_pb    [NUM_STEPS][NUM_PORTS];
  logic [DROP_W-1:0] exp_cnt   [NUM_STEPS][NUM_PORTS];
  logic [NUM_TC-1:0] exp_pause [NUM_STEPS];

  int errors;
  int checks;
  int cycles;

  igr_dpc_top #(
    .DROP_CNT_W (DROP_W)
  ) UUT (
    .i_cclk        (cclk),
    .i_rst         (rst),
    .i_rx_data_v   (rx_data_v),
    .i_rx_port_num (rx_port_num),
    .i_rx_data     (rx_data),
    .i_rx_md       (rx_md),
    .i_rx_ts       (rx_ts),
    .i_pfc_strobe  (pfc_strobe),
    .i_pfc_xoff    (pfc_xoff),
    .i_pfc_tc      (pfc_tc),
    .o_dpc_pb      (dpc_pb),
    .o_drop_cnt    (drop_cnt),
    .o_pause_tc    (pause_tc)
  );

  initial begin
    cclk = 1'b0;
    forever #5 cclk = ~cclk;
  end

  //----------------------------------------------------------------------
  // compare tasks
  //----------------------------------------------------------------------

  task automatic check_pb(input int port, input dpc_pb_t got, input dpc_pb_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED o_dpc_pb[%0d] got %h expected %h", port, got, exp);
    end
  endtask

  task automatic check_cnt(input int port, input logic [DROP_W-1:0] got,
                           input logic [DROP_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED o_drop_cnt[%0d] got %h expected %h", port, got, exp);
    end
  endtask

  task automatic check_pause(input logic [NUM_TC-1:0] got, input logic [NUM_TC-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED o_pause_tc got %h expected %h", got, exp);
    end
  endtask

  //----------------------------------------------------------------------
  // drive one bus cycle and step the model
  //----------------------------------------------------------------------

  task automatic apply_step(input int j);
    vec_t                          v;
    data64_w_ecc_t [0:NUM_WORDS-1] d;
    epl_md_t                       md;
    int                            p;
    // past the table the bus stays idle while the pipe empties
    v = (j < NUM_VEC) ? VECS[j] : '0;
    for (int w = 0; w < NUM_WORDS; w++) begin
      d[w].data = {$urandom(), $urandom()};
      d[w].ecc  = 8'($urandom());
    end
    {md.multi, md.fast, md.fcs_hint, md.dei, md.error} = v.flags;
    md.eop      = v.eop;
    md.eop_pos  = 3'($urandom());
    md.byte_pos = 3'($urandom());
    md.sop      = v.sop;
    md.sop_pos  = 3'($urandom());
    md.tc       = v.tc;
    rx_data_v   <= v.mask;
    rx_port_num <= v.port;
    rx_data     <= d;
    rx_md       <= md;
    rx_ts       <= v.ts;
    pfc_strobe  <= v.pfc_strobe;
    pfc_xoff    <= v.pfc_xoff;
    pfc_tc      <= v.pfc_tc;
    // valid is a pulse, captured fields hold
    for (int q = 0; q < NUM_PORTS; q++) begin
      model_pb[q].v = 1'b0;
    end
    if (v.mask != '0) begin
      p = int'(v.port);
      if (v.sop || in_pkt[p]) begin
        model_pb[p].v                = 1'b1;
        model_pb[p].tsmd.ts          = v.ts;
        model_pb[p].tsmd.md.word_cnt = CNT_W'($countones(v.mask));
        model_pb[p].tsmd.md.epl      = md;
        model_pb[p].d                = d;
        in_pkt[p]                    = !v.eop;
      end else if (model_cnt[p] != '1) begin
        model_cnt[p] = model_cnt[p] + DROP_W'(1);
      end
    end
    if (v.pfc_strobe) begin
      model_pause[v.pfc_tc] = v.pfc_xoff;
    end
    for (int q = 0; q < NUM_PORTS; q++) begin
      exp_pb[j][q]  = model_pb[q];
      exp_cnt[j][q] = model_cnt[q];
    end
    exp_pause[j] = model_pause;
  endtask

  //----------------------------------------------------------------------
  // main sequence
  //----------------------------------------------------------------------

  initial begin
    void'($urandom(SEED));
    errors      = 0;
    checks      = 0;
    rst         = 1'b1;
    rx_data_v   = '0;
    rx_port_num = '0;
    rx_data     = '0;
    rx_md       = '0;
    rx_ts       = '0;
    pfc_strobe  = 1'b0;
    pfc_xoff    = 1'b0;
    pfc_tc      = '0;
    model_pause = '0;
    for (int q = 0; q < NUM_PORTS; q++) begin
      model_pb[q]  = '0;
      in_pkt[q]    = 1'b0;
      model_cnt[q] = '0;
    end
    repeat (RST_CYCLES) @(posedge cclk);
    rst <= 1'b0;
    // everything comes out of reset cleared
    @(negedge cclk);
    for (int q = 0; q < NUM_PORTS; q++) begin
      check_pb(q, dpc_pb[q], '0);
      check_cnt(q, drop_cnt[q], '0);
    end
    check_pause(pause_tc, '0);
    // sample at the falling edge, results of step j-LAT are settled there
    for (int j = 0; j < NUM_STEPS; j++) begin
      @(posedge cclk);
      apply_step(j);
      @(negedge cclk);
      if (j >= LAT) begin
        for (int q = 0; q < NUM_PORTS; q++) begin
          check_pb(q, dpc_pb[q], exp_pb[j-LAT][q]);
          check_cnt(q, drop_cnt[q], exp_cnt[j-LAT][q]);
        end
      end
      if (j >= 1) begin
        check_pause(pause_tc, exp_pause[j-1]);
      end
    end
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // run limit
  always @(posedge cclk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

endmodule

// ==== igr_dpc_top.f ====
+incdir+bench
hdl/igr_dpc_pkg.sv
hdl/igr_rx_stage.sv
hdl/igr_port_lane.sv
hdl/igr_pb_drain.sv
hdl/igr_dpc_top.sv
bench/igr_dpc_tb.sv

// ==== Makefile ====
# Verilator build and run of the ingress data path control testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -j 0 --top-module igr_dpc_tb \
		-f igr_dpc_top.f -o Vigr_dpc_tb
	./obj_dir/Vigr_dpc_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG) || ! grep -qF '*** PASSED ***' $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
